//--- hdl/file_io_pkg.sv
// struct widths come from the defaults below, so top-level parameters must match; at most 16 banks
`default_nettype none

package file_io_pkg;

  // ********************
  // sizing defaults
  // ********************
  localparam int NUM_BANKS    = 2;
  localparam int DEPTH        = 4;
  localparam int WORD_NIBBLES = 4;

  localparam int BANK_W = (NUM_BANKS > 1) ? $clog2(NUM_BANKS) : 1;
  localparam int ADDR_W = (DEPTH > 1) ? $clog2(DEPTH) : 1;
  localparam int NIB_W  = (WORD_NIBBLES > 1) ? $clog2(WORD_NIBBLES) : 1;
  localparam int WORD_W = 4 * WORD_NIBBLES;

  // framing characters of the text file
  typedef enum logic [7:0] {
    SOH = 8'h01,  // file header start
    SOT = 8'h02,  // text start, data follows
    EOT = 8'h03,  // end of file name
    EOF = 8'h04,
    LF  = 8'h0A,
    CR  = 8'h0D
  } char_code_e;

  // transfer controller modes
  typedef enum logic [2:0] {
    IDLE,
    WAIT_SOT,
    LOAD,
    DUMP,
    DUMP_DRAIN
  } xfer_state_e;

  // ********************
  // memory ports
  // ********************
  typedef struct packed {
    logic              we;    // write strobe
    logic [BANK_W-1:0] bank;
    logic [ADDR_W-1:0] addr;
    logic [WORD_W-1:0] word;
  } mem_wr_t;

  typedef struct packed {
    logic [BANK_W-1:0] bank;
    logic [ADDR_W-1:0] addr;
  } mem_rd_t;

  // {valid, value}; 0-9, A-F and a-f are digits
  function automatic logic [4:0] hex_to_nibble(input logic [7:0] ch);
    logic [4:0] res;
    res = 5'b0_0000;
    if (ch >= 8'h30 && ch <= 8'h39)
      res = {1'b1, ch[3:0]};
    else if ((ch >= 8'h41 && ch <= 8'h46) || (ch >= 8'h61 && ch <= 8'h66))
      res = {1'b1, ch[3:0] + 4'h9};  // low nibble of A/a is 1
    return res;
  endfunction

  // uppercase ascii digit
  function automatic logic [7:0] nibble_to_hex(input logic [3:0] nib);
    logic [7:0] res;
    if (nib <= 4'h9)
      res = {4'h3, nib};
    else
      res = 8'h37 + {4'h0, nib};  // 10 -> 'A'
    return res;
  endfunction

endpackage

`default_nettype wire

//--- hdl/transfer_ctrl.sv
// one transfer at a time; requests while busy are dropped and a dump beats a load in the same cycle
`timescale 1ns/1ns
`default_nettype none

module transfer_ctrl
  import file_io_pkg::*;
(
  input  logic              clk_sys,
  input  logic              rst_clk,
  input  logic              load_req_i,
  input  logic [BANK_W-1:0] load_bank_i,
  input  logic              dump_req_i,
  input  logic              load_last_i,  // parser wrote last address
  input  logic              dump_end_i,   // formatter sent last EOF
  output logic              rx_en_o,
  output logic [BANK_W-1:0] bank_o,
  output logic              dump_go_o,
  output logic              busy_o,
  output logic              done_o
);

  xfer_state_e       state_q;  // also the mode register
  logic [BANK_W-1:0] bank_q;   // bank selected by the load request
  logic              done_q;

  // ********************
  // mode FSM
  // ********************
  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      state_q <= IDLE;
      bank_q  <= '0;
      done_q  <= 1'b0;
    end
    else
    begin
      done_q <= 1'b0;
      case (state_q)
        IDLE:
        begin
          if (dump_req_i)  // dump has priority
            state_q <= DUMP;
          else if (load_req_i)
          begin
            state_q <= WAIT_SOT;
            bank_q  <= load_bank_i;
          end
        end
        WAIT_SOT, LOAD:  // parser armed, searching SOT then words
        begin
          if (load_last_i)
          begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
          else
            state_q <= LOAD;
        end
        DUMP:
          state_q <= DUMP_DRAIN;  // single go pulse
        DUMP_DRAIN:
        begin
          if (dump_end_i)
          begin
            state_q <= IDLE;
            done_q  <= 1'b1;
          end
        end
        default:
          state_q <= IDLE;
      endcase
    end
  end

  assign rx_en_o   = (state_q == WAIT_SOT) || (state_q == LOAD);
  assign dump_go_o = (state_q == DUMP);
  assign busy_o    = (state_q != IDLE);  // one cycle after the request
  assign bank_o    = bank_q;
  assign done_o    = done_q;

endmodule

`default_nettype wire

//--- hdl/hex_rx_parser.sv
// digits before SOT and all non-hex characters are dropped; a load always fills the whole bank
`timescale 1ns/1ns
`default_nettype none

module hex_rx_parser
  import file_io_pkg::*;
#(
  parameter int DEPTH        = file_io_pkg::DEPTH,
  parameter int WORD_NIBBLES = file_io_pkg::WORD_NIBBLES
)
(
  input  logic              clk_sys,
  input  logic              rst_clk,
  input  logic              rx_en_i,
  input  logic [BANK_W-1:0] bank_i,
  input  logic              rx_valid_i,
  input  logic [7:0]        rx_char_i,
  output mem_wr_t           wr_o,
  output logic              load_last_o
);

  logic              armed_q;    // SOT seen
  logic [NIB_W-1:0]  nib_cnt_q;
  logic [ADDR_W-1:0] addr_q;     // next write address
  logic              we_q;
  logic              last_q;
  logic [WORD_W-1:0] word_q;     // shift register, msd first
  logic [BANK_W-1:0] wr_bank_q;
  logic [ADDR_W-1:0] wr_addr_q;
  logic [WORD_W-1:0] wr_word_q;
  logic [4:0]        nib_res;
  logic [WORD_W-1:0] word_next;
  logic              nib_take;
  logic              word_full;

  assign nib_res   = hex_to_nibble(rx_char_i);
  assign nib_take  = rx_en_i && armed_q && rx_valid_i && nib_res[4];
  assign word_next = WORD_W'({word_q, nib_res[3:0]});  // oldest digit falls off the top
  assign word_full = (nib_cnt_q == NIB_W'(WORD_NIBBLES - 1));

  // counters, cleared whenever the controller is not loading
  always_ff @(posedge clk_sys)
  begin
    if (rst_clk || !rx_en_i)
    begin
      armed_q   <= 1'b0;
      nib_cnt_q <= '0;
      addr_q    <= '0;
      we_q      <= 1'b0;
      last_q    <= 1'b0;
    end
    else
    begin
      we_q   <= 1'b0;
      last_q <= 1'b0;
      if (rx_valid_i && !armed_q && rx_char_i == SOT)
        armed_q <= 1'b1;
      if (nib_take)
      begin
        if (word_full)
        begin
          nib_cnt_q <= '0;
          we_q      <= 1'b1;
          if (addr_q == ADDR_W'(DEPTH - 1))
          begin
            addr_q  <= '0;
            last_q  <= 1'b1;  // same cycle as the final write
            armed_q <= 1'b0;  // back to SOT search
          end
          else
            addr_q <= addr_q + 1'b1;
        end
        else
          nib_cnt_q <= nib_cnt_q + 1'b1;
      end
    end
  end

  // word and write payload
  always_ff @(posedge clk_sys)
  begin
    if (nib_take)
    begin
      word_q <= word_next;
      if (word_full)
      begin
        wr_bank_q <= bank_i;
        wr_addr_q <= addr_q;
        wr_word_q <= word_next;
      end
    end
  end

  assign wr_o        = '{we: we_q, bank: wr_bank_q, addr: wr_addr_q, word: wr_word_q};
  assign load_last_o = last_q;

endmodule

`default_nettype wire

//--- hdl/word_store.sv
// contents are undefined until loaded; read data appears one clock after the read address
`timescale 1ns/1ns
`default_nettype none

module word_store
  import file_io_pkg::*;
#(
  parameter int NUM_BANKS    = file_io_pkg::NUM_BANKS,
  parameter int DEPTH        = file_io_pkg::DEPTH,
  parameter int WORD_NIBBLES = file_io_pkg::WORD_NIBBLES
)
(
  input  logic                      clk_sys,
  input  mem_wr_t                   wr_i,
  input  mem_rd_t                   rd_i,
  output logic [4*WORD_NIBBLES-1:0] rd_word_o
);

  // ********************
  // bank array
  // ********************
  logic [4*WORD_NIBBLES-1:0] mem_q [NUM_BANKS][DEPTH];

  always_ff @(posedge clk_sys)
  begin
    if (wr_i.we)
      mem_q[wr_i.bank][wr_i.addr] <= wr_i.word;  // from parser
    rd_word_o <= mem_q[rd_i.bank][rd_i.addr];    // registered read for formatter
  end

endmodule

`default_nettype wire

//--- hdl/hex_tx_formatter.sv
// dumps every bank in order; holds all state while tx_full_i is high, so nothing is lost or repeated
`timescale 1ns/1ns
`default_nettype none

module hex_tx_formatter
  import file_io_pkg::*;
#(
  parameter int NUM_BANKS    = file_io_pkg::NUM_BANKS,
  parameter int DEPTH        = file_io_pkg::DEPTH,
  parameter int WORD_NIBBLES = file_io_pkg::WORD_NIBBLES
)
(
  input  logic                      clk_sys,
  input  logic                      rst_clk,
  input  logic                      dump_go_i,
  input  logic                      tx_full_i,
  output mem_rd_t                   rd_o,
  input  logic [4*WORD_NIBBLES-1:0] rd_word_i,
  output logic [7:0]                tx_char_o,
  output logic                      tx_we_o,
  output logic                      dump_end_o
);

  localparam int ROW_LEN  = WORD_NIBBLES + 2;         // digits, CR, LF
  localparam int FILE_LEN = 4 + DEPTH * ROW_LEN + 1;  // header, rows, EOF
  localparam int CNT_W    = $clog2(FILE_LEN);
  localparam int COL_W    = $clog2(ROW_LEN);

  logic              active_q;
  logic [CNT_W-1:0]  char_cnt_q;  // position in current file
  logic [COL_W-1:0]  col_q;       // position in current row
  logic [ADDR_W-1:0] addr_q;      // read address, runs ahead of the row
  logic [BANK_W-1:0] bank_q;
  logic              accept;
  logic              is_eof;
  logic              in_rows;
  logic              last_bank;
  logic [COL_W-1:0]  dig_idx;
  logic [3:0]        digit;
  logic [3:0]        bank_nib;

  assign accept     = active_q && !tx_full_i;
  assign tx_we_o    = accept;  // never while full
  assign is_eof     = (char_cnt_q == CNT_W'(FILE_LEN - 1));
  assign in_rows    = (char_cnt_q >= CNT_W'(4)) && !is_eof;
  assign last_bank  = (bank_q == BANK_W'(NUM_BANKS - 1));
  assign dump_end_o = accept && is_eof && last_bank;
  assign bank_nib   = 4'(bank_q);

  // nibble index counted from the lsb, msd goes out first
  assign dig_idx = (col_q < COL_W'(WORD_NIBBLES)) ? COL_W'(WORD_NIBBLES - 1) - col_q : '0;
  assign digit   = rd_word_i[4*dig_idx +: 4];

  // ********************
  // character select
  // ********************
  always_comb
  begin
    if (char_cnt_q == CNT_W'(0))
      tx_char_o = SOH;
    else if (char_cnt_q == CNT_W'(1))
      tx_char_o = nibble_to_hex(bank_nib);  // file name
    else if (char_cnt_q == CNT_W'(2))
      tx_char_o = EOT;
    else if (char_cnt_q == CNT_W'(3))
      tx_char_o = SOT;
    else if (is_eof)
      tx_char_o = EOF;
    else if (col_q < COL_W'(WORD_NIBBLES))
      tx_char_o = nibble_to_hex(digit);
    else if (col_q == COL_W'(WORD_NIBBLES))
      tx_char_o = CR;
    else
      tx_char_o = LF;
  end

  // ********************
  // counters
  // ********************
  always_ff @(posedge clk_sys)
  begin
    if (rst_clk)
    begin
      active_q   <= 1'b0;
      char_cnt_q <= '0;
      col_q      <= '0;
      addr_q     <= '0;
      bank_q     <= '0;
    end
    else if (dump_go_i)
    begin
      active_q   <= 1'b1;
      char_cnt_q <= '0;
      col_q      <= '0;
      addr_q     <= '0;  // row 0 fetched during the header
      bank_q     <= '0;
    end
    else if (accept)
    begin
      if (is_eof)
      begin
        char_cnt_q <= '0;
        col_q      <= '0;
        addr_q     <= '0;
        if (last_bank)
        begin
          active_q <= 1'b0;
          bank_q   <= '0;
        end
        else
          bank_q <= bank_q + 1'b1;  // next file
      end
      else
      begin
        char_cnt_q <= char_cnt_q + 1'b1;
        if (in_rows)
        begin
          col_q <= (col_q == COL_W'(ROW_LEN - 1)) ? '0 : col_q + 1'b1;
          // CR accepted, LF still to go, covers the read latency
          if (col_q == COL_W'(WORD_NIBBLES))
            addr_q <= (addr_q == ADDR_W'(DEPTH - 1)) ? '0 : addr_q + 1'b1;
        end
      end
    end
  end

  assign rd_o = '{bank: bank_q, addr: addr_q};

endmodule

`default_nettype wire

//--- hdl/hex_file_io_top.sv
// parameters must equal the file_io_pkg defaults, since the memory structs are sized by them
`timescale 1ns/1ns
`default_nettype none

module hex_file_io_top
  import file_io_pkg::*;
#(
  parameter int NUM_BANKS    = file_io_pkg::NUM_BANKS,
  parameter int DEPTH        = file_io_pkg::DEPTH,
  parameter int WORD_NIBBLES = file_io_pkg::WORD_NIBBLES
)
(
  input  logic              clk_sys,
  input  logic              rst_clk,
  input  logic              rx_valid_i,   // one-cycle char strobe
  input  logic [7:0]        rx_char_i,
  input  logic              load_req_i,
  input  logic [BANK_W-1:0] load_bank_i,
  input  logic              dump_req_i,
  input  logic              tx_full_i,
  output logic [7:0]        tx_char_o,
  output logic              tx_we_o,
  output logic              busy_o,
  output logic              done_o
);

  logic                      rx_en;
  logic [BANK_W-1:0]         bank;
  logic                      load_last;
  logic                      dump_go;
  logic                      dump_end;
  mem_wr_t                   wr;
  mem_rd_t                   rd;
  logic [4*WORD_NIBBLES-1:0] rd_word;

  transfer_ctrl u_transfer_ctrl (
    .clk_sys     (clk_sys),
    .rst_clk     (rst_clk),
    .load_req_i  (load_req_i),
    .load_bank_i (load_bank_i),
    .dump_req_i  (dump_req_i),
    .load_last_i (load_last),
    .dump_end_i  (dump_end),
    .rx_en_o     (rx_en),
    .bank_o      (bank),
    .dump_go_o   (dump_go),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  hex_rx_parser #(.DEPTH(DEPTH), .WORD_NIBBLES(WORD_NIBBLES)) u_hex_rx_parser (
    .clk_sys     (clk_sys),
    .rst_clk     (rst_clk),
    .rx_en_i     (rx_en),
    .bank_i      (bank),
    .rx_valid_i  (rx_valid_i),
    .rx_char_i   (rx_char_i),
    .wr_o        (wr),
    .load_last_o (load_last)
  );

  word_store #(.NUM_BANKS(NUM_BANKS), .DEPTH(DEPTH), .WORD_NIBBLES(WORD_NIBBLES)) u_word_store (
    .clk_sys   (clk_sys),
    .wr_i      (wr),
    .rd_i      (rd),
    .rd_word_o (rd_word)
  );

  hex_tx_formatter #(
    .NUM_BANKS    (NUM_BANKS),
    .DEPTH        (DEPTH),
    .WORD_NIBBLES (WORD_NIBBLES)
  ) u_hex_tx_formatter (
    .clk_sys    (clk_sys),
    .rst_clk    (rst_clk),
    .dump_go_i  (dump_go),
    .tx_full_i  (tx_full_i),
    .rd_o       (rd),
    .rd_word_i  (rd_word),
    .tx_char_o  (tx_char_o),
    .tx_we_o    (tx_we_o),
    .dump_end_o (dump_end)
  );

endmodule

`default_nettype wire

//--- testbench/clk_rst_gen.sv
// free-running clock from time 0; reset is released 1 ns after its last edge, never on an edge
`timescale 1ns/1ns
`default_nettype none

module clk_rst_gen #(
  parameter int PERIOD_NS  = 10,
  parameter int RST_CYCLES = 4
)
(
  output logic clk_sys,
  output logic rst_clk
);

  initial
  begin
    clk_sys = 1'b0;
    forever #(PERIOD_NS / 2) clk_sys = ~clk_sys;
  end

  initial
  begin
    rst_clk = 1'b1;
    repeat (RST_CYCLES) @(posedge clk_sys);  // sync reset sees 4 edges
    #1 rst_clk = 1'b0;
  end

endmodule

`default_nettype wire

//--- testbench/tb_hex_file_io.sv
// sized for 2 banks x 4 words x 4 nibbles; random words and tx_full_i pattern come from seed 84731
`timescale 1ns/1ns
`default_nettype none

module tb_hex_file_io;

  localparam int NUM_BANKS      = 2;
  localparam int DEPTH          = 4;
  localparam int WORD_NIBBLES   = 4;
  localparam int NUM_STEPS      = 7;
  localparam int TIMEOUT_CYCLES = NUM_STEPS * 400;

  // one row of the stimulus table
  typedef struct packed {
    logic                                 is_dump;
    logic                                 bank;
    logic                                 noise;      // junk before SOT and between digits
    logic                                 lower;      // a-f instead of A-F
    logic                                 poke;       // load_req with and during the dump
    logic [6:0]                           stall_pct;  // tx_full_i rate in percent
    logic [DEPTH-1:0][4*WORD_NIBBLES-1:0] words;
  } step_t;

  logic       clk_sys;
  logic       rst_clk;
  logic       rx_valid_i;
  logic [7:0] rx_char_i;
  logic       load_req_i;
  logic [0:0] load_bank_i;
  logic       dump_req_i;
  logic       tx_full_i;
  logic [7:0] tx_char_o;
  logic       tx_we_o;
  logic       busy_o;
  logic       done_o;

  step_t                     steps [NUM_STEPS];
  logic [4*WORD_NIBBLES-1:0] model [NUM_BANKS][DEPTH];  // expected bank contents
  logic [7:0]                exp_q [$];
  logic [7:0]                got_q [$];                 // accepted tx chars
  int                        err_cnt   = 0;
  int                        chk_cnt   = 0;
  int                        done_cnt  = 0;
  int                        cycle_cnt = 0;
  logic                      in_dump   = 1'b0;          // dump step running
  logic                      we_prev   = 1'b0;          // char accepted last cycle
  logic                      done_prev = 1'b0;

  clk_rst_gen #(.PERIOD_NS(10), .RST_CYCLES(4)) u_clk_rst_gen (
    .clk_sys (clk_sys),
    .rst_clk (rst_clk)
  );

  hex_file_io_top #(
    .NUM_BANKS    (NUM_BANKS),
    .DEPTH        (DEPTH),
    .WORD_NIBBLES (WORD_NIBBLES)
  ) u_hex_file_io_top (
    .clk_sys     (clk_sys),
    .rst_clk     (rst_clk),
    .rx_valid_i  (rx_valid_i),
    .rx_char_i   (rx_char_i),
    .load_req_i  (load_req_i),
    .load_bank_i (load_bank_i),
    .dump_req_i  (dump_req_i),
    .tx_full_i   (tx_full_i),
    .tx_char_o   (tx_char_o),
    .tx_we_o     (tx_we_o),
    .busy_o      (busy_o),
    .done_o      (done_o)
  );

  // ********************
  // helpers
  // ********************
  task automatic next_cycle();
    @(posedge clk_sys);
    #1;  // drive just after the edge
  endtask

  function automatic logic [7:0] hex_char(input logic [3:0] v, input logic lower);
    if (v < 4'd10)
      return 8'h30 + 8'(v);
    return (lower ? 8'h61 : 8'h41) + 8'(v) - 8'd10;
  endfunction

  function automatic logic [7:0] noise_char();
    string pool;
    pool = "gx -Z:";  // none of these is a hex digit
    return pool[$urandom_range(5)];
  endfunction

  function automatic step_t make_load(input logic bank, input logic noise, input logic lower);
    step_t s;
    s       = '0;
    s.bank  = bank;
    s.noise = noise;
    s.lower = lower;
    for (int a = 0; a < DEPTH; a++)
      s.words[a] = 16'($urandom);
    return s;
  endfunction

  function automatic step_t make_dump(input int stall_pct, input logic poke);
    step_t s;
    s           = '0;
    s.is_dump   = 1'b1;
    s.stall_pct = 7'(stall_pct);
    s.poke      = poke;
    return s;
  endfunction

  task automatic run_load(input step_t s);
    logic [7:0] chars [$];
    int         start_done;
    if (s.noise)
    begin
      chars.push_back(8'h37);  // '7' before SOT is dropped
      chars.push_back(8'h46);  // 'F'
      chars.push_back(noise_char());
    end
    chars.push_back(8'h02);  // SOT
    for (int a = 0; a < DEPTH; a++)
      for (int n = WORD_NIBBLES - 1; n >= 0; n--)
      begin
        if (s.noise && $urandom_range(1))
          chars.push_back(noise_char());
        chars.push_back(hex_char(s.words[a][4*n +: 4], s.lower));  // msd first
      end
    start_done  = done_cnt;
    load_req_i  = 1'b1;
    load_bank_i = s.bank;
    next_cycle();
    load_req_i = 1'b0;
    if (busy_o !== 1'b1)
    begin
      $display("FAIL t=%0t busy_o got %b exp 1", $time, busy_o);
      err_cnt++;
    end
    foreach (chars[i])
    begin
      rx_valid_i = 1'b1;
      rx_char_i  = chars[i];
      next_cycle();
      rx_valid_i = 1'b0;
      repeat (s.noise ? $urandom_range(2) : 0) next_cycle();  // idle gaps
    end
    while (done_cnt == start_done)
      next_cycle();
    for (int a = 0; a < DEPTH; a++)
      model[s.bank][a] = s.words[a];
  endtask

  task automatic run_dump(input step_t s);
    int start_done;
    int k;
    exp_q.delete();
    got_q.delete();
    for (int b = 0; b < NUM_BANKS; b++)  // 29 chars per bank
    begin
      exp_q.push_back(8'h01);                   // SOH
      exp_q.push_back(hex_char(4'(b), 1'b0));   // bank digit
      exp_q.push_back(8'h03);                   // EOT
      exp_q.push_back(8'h02);                   // SOT
      for (int a = 0; a < DEPTH; a++)
      begin
        for (int n = WORD_NIBBLES - 1; n >= 0; n--)
          exp_q.push_back(hex_char(model[b][a][4*n +: 4], 1'b0));
        exp_q.push_back(8'h0D);
        exp_q.push_back(8'h0A);
      end
      exp_q.push_back(8'h04);  // EOF
    end
    start_done  = done_cnt;
    k           = 0;
    in_dump     = 1'b1;
    dump_req_i  = 1'b1;
    load_req_i  = s.poke;  // same cycle as the dump, which must win
    load_bank_i = 1'b1;
    next_cycle();
    dump_req_i = 1'b0;
    load_req_i = 1'b0;
    if (busy_o !== 1'b1)
    begin
      $display("FAIL t=%0t busy_o got %b exp 1", $time, busy_o);
      err_cnt++;
    end
    while (done_cnt == start_done)
    begin
      tx_full_i  = ($urandom_range(99) < s.stall_pct);
      load_req_i = s.poke && (k == 20);  // mid-dump request is ignored
      next_cycle();
      k++;
    end
    in_dump    = 1'b0;
    tx_full_i  = 1'b0;
    load_req_i = 1'b0;
    if (got_q.size() != exp_q.size())
    begin
      $display("FAIL t=%0t dump length got %0d exp %0d", $time, got_q.size(), exp_q.size());
      err_cnt++;
    end
    else
      foreach (exp_q[i])
      begin
        chk_cnt++;
        if (got_q[i] !== exp_q[i])
        begin
          $display("FAIL t=%0t tx_char_o[%0d] got %h exp %h", $time, i, got_q[i], exp_q[i]);
          err_cnt++;
        end
      end
  endtask

  // ********************
  // mid-cycle monitor
  // ********************
  always @(negedge clk_sys)
  begin
    if (!rst_clk)
    begin
      if (tx_we_o)
        got_q.push_back(tx_char_o);
      if (tx_we_o && tx_full_i)
      begin
        $display("FAIL t=%0t tx_we_o got 1 exp 0 (tx_full_i high)", $time);
        err_cnt++;
      end
      if (done_o)
      begin
        done_cnt++;
        if (busy_o !== 1'b0)
        begin
          $display("FAIL t=%0t busy_o got %b exp 0 at done", $time, busy_o);
          err_cnt++;
        end
        if (done_prev)
        begin
          $display("FAIL t=%0t done_o got 1 exp 0 (pulse longer than one cycle)", $time);
          err_cnt++;
        end
        // done follows the final EOF by exactly one cycle
        if (in_dump && (!we_prev || got_q.size() != exp_q.size()))
        begin
          $display("FAIL t=%0t done_o got 1 exp 0 (last EOF not accepted one cycle before)",
                   $time);
          err_cnt++;
        end
      end
      we_prev   = tx_we_o;
      done_prev = done_o;
    end
  end

  always @(posedge clk_sys)
    cycle_cnt <= cycle_cnt + 1;

  initial
  begin
    wait (cycle_cnt >= TIMEOUT_CYCLES);
    $display("timeout: run did not end within %0d cycles", TIMEOUT_CYCLES);
    $display("*** FAILED ***");
    $finish;
  end

  // ********************
  // main sequence
  // ********************
  initial
  begin
    rx_valid_i  = 1'b0;
    rx_char_i   = 8'h00;
    load_req_i  = 1'b0;
    load_bank_i = 1'b0;
    dump_req_i  = 1'b0;
    tx_full_i   = 1'b0;
    void'($urandom(84731));
    steps[0] = make_load(1'b0, 1'b0, 1'b0);  // plain upper case
    steps[1] = make_load(1'b1, 1'b1, 1'b1);  // noise and lower case
    steps[2] = make_dump(0, 1'b0);
    steps[3] = make_load(1'b0, 1'b1, 1'b0);
    steps[4] = make_dump(40, 1'b0);          // heavy back-pressure
    steps[5] = make_dump(25, 1'b1);          // stray load requests
    steps[6] = make_dump(10, 1'b0);          // contents unchanged
    wait (rst_clk === 1'b0);
    repeat (3)
    begin
      @(negedge clk_sys);
      if (tx_we_o !== 1'b0 || busy_o !== 1'b0 || done_o !== 1'b0)
      begin
        $display("FAIL t=%0t tx_we_o/busy_o/done_o got %b%b%b exp 000",
                 $time, tx_we_o, busy_o, done_o);
        err_cnt++;
      end
    end
    next_cycle();
    for (int i = 0; i < NUM_STEPS; i++)
    begin
      if (steps[i].is_dump)
        run_dump(steps[i]);
      else
        run_load(steps[i]);
      repeat (2) next_cycle();
    end
    $display("errors: %0d, characters compared: %0d", err_cnt, chk_cnt);
    if (err_cnt == 0)
      $display("*** PASSED ***");
    else
      $display("*** FAILED ***");
    $finish;
  end

endmodule

`default_nettype wire

//--- compile.f
hdl/file_io_pkg.sv
hdl/transfer_ctrl.sv
hdl/hex_rx_parser.sv
hdl/word_store.sv
hdl/hex_tx_formatter.sv
hdl/hex_file_io_top.sv
testbench/clk_rst_gen.sv
testbench/tb_hex_file_io.sv
